//--- build.f
+incdir+hw
hw/lane_pkg.sv
hw/path_sel.sv
hw/lane_regfile.sv
hw/lane_alu.sv
hw/simd_lane.sv
hw/lane_array.sv
dv/lane_array_checker.sv
dv/lane_array_tb.sv

//--- dv/lane_array_checker.sv
/*
 * Timing rules of the done strobe and the result bus, bound to lane_array.
 * Holds no data model; issue must stay low while rst_n is low.
 */

`timescale 1ns/1ps

module lane_array_checker (
	input logic            clk,
	input logic            rst_n,
	input logic            issue,
	input logic            done,
	input lane_pkg::lane_t result
);

	int unsigned error_count = 0;  // Read by the testbench

	////////////////////////////////////////////////////////////
	// Done strobe
	////////////////////////////////////////////////////////////

	// Exactly two cycles after each issue, and never otherwise
	done_latency: assert property (@(posedge clk) disable iff (!rst_n)
		done == $past(issue, 2))
	else begin
		$error("done does not follow issue by exactly two cycles");
		error_count++;
	end

	////////////////////////////////////////////////////////////
	// Quiet outputs
	////////////////////////////////////////////////////////////

	reset_quiet: assert property (@(posedge clk) !rst_n |-> !done && result == '0)
	else begin
		$error("done or result is not zero while in reset");
		error_count++;
	end

	release_quiet: assert property (@(posedge clk) $rose(rst_n) |-> !done && result == '0)
	else begin
		$error("done or result is not zero on the first cycle after reset");
		error_count++;
	end

	idle_result: assert property (@(posedge clk) disable iff (!rst_n) !done |-> result == '0)
	else begin
		$error("result is not zero while done is low");
		error_count++;
	end

endmodule

bind lane_array lane_array_checker checker_i (
	.clk(clk), .rst_n(rst_n), .issue(issue), .done(done), .result(result)
);

//--- dv/lane_array_tb.sv
/*
 * Testbench for the lane array. A reference model of all lane registers
 * sets the expected write-back values; assertions compare them on done.
 */

`timescale 1ns/1ps
`include "lane_macros.svh"

module lane_array_tb;

	localparam int N          = `NUM_LANES;
	localparam int MAX_CYCLES = 400;     // About three times the test length

	logic                clk;
	logic                rst_n;
	logic                issue;
	lane_pkg::alu_op_t   op;
	lane_pkg::reg_addr_t src1_addr, src2_addr, src3_addr, dst_addr;
	lane_pkg::path_sel_t sel_path, sel_path_wb;
	lane_pkg::data_t     scalar;
	logic                done;
	lane_pkg::lane_t     result;

	// Reference model, one stage per DUT pipeline stage
	lane_pkg::data_t     model_rf [N][`RF_DEPTH];
	logic                ex_v, wb_v;
	lane_pkg::alu_op_t   ex_op;
	lane_pkg::reg_addr_t ex_dst, wb_dst;
	lane_pkg::path_sel_t ex_wb_sel;
	lane_pkg::data_t     ex_a [N], ex_b [N], ex_c [N];
	lane_pkg::lane_t     exp_result;     // Values written at the next done

	int err_count  = 0;
	int errs_seen  = 0;
	int pass_count = 0;
	int fail_count = 0;
	int cycles     = 0;

	lane_array dut_i (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: run stopped after %0d cycles", cycles);
			$display("Simulation failed");
			$finish;
		end
	end

	function automatic lane_pkg::data_t alu_model(input lane_pkg::alu_op_t f,
			input lane_pkg::data_t a, input lane_pkg::data_t b, input lane_pkg::data_t c);
		logic [2*`DATA_W-1:0] full;
		full = {{`DATA_W{1'b0}}, a} * {{`DATA_W{1'b0}}, b};
		case (f)
			lane_pkg::op_add:     return a + b;
			lane_pkg::op_sub:     return a - b;
			lane_pkg::op_mul_add: return full[`DATA_W-1:0] + c;  // Low half plus c
			lane_pkg::op_max:     return ($signed(a) < $signed(b)) ? b : a;
			lane_pkg::op_pass:    return a;
			default:              return '0;
		endcase
	endfunction

	////////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////////

	always @(posedge clk or negedge rst_n) begin : ref_model
		lane_pkg::data_t alu_out [N];
		lane_pkg::data_t ra, rb, rc;
		int              s;
		if (!rst_n) begin
			for (int l = 0; l < N; l++)
				for (int k = 0; k < `RF_DEPTH; k++)
					model_rf[l][k] <= '0;
			ex_v <= 1'b0;
			wb_v <= 1'b0;
		end else begin
			if (wb_v)                                     // Write lands after this edge
				for (int l = 0; l < N; l++)
					model_rf[l][wb_dst] <= exp_result[l];
			wb_v <= ex_v;
			if (ex_v) begin
				for (int l = 0; l < N; l++)
					alu_out[l] = alu_model(ex_op, ex_a[l], ex_b[l], ex_c[l]);
				for (int l = 0; l < N; l++) begin
					s = (l + int'(ex_wb_sel[3:0])) % N;
					if (ex_wb_sel[4])
						exp_result[l] <= alu_out[s];          // Neighbour result
					else if (ex_wb_sel[1:0] == 2'd1)
						exp_result[l] <= ex_a[l];
					else if (ex_wb_sel[1:0] == 2'd2)
						exp_result[l] <= ex_b[l];
					else if (ex_wb_sel[1:0] == 2'd3)
						exp_result[l] <= ex_c[l];
					else
						exp_result[l] <= alu_out[l];
				end
				wb_dst <= ex_dst;
			end
			ex_v <= issue;
			if (issue) begin
				ex_op     <= op;
				ex_dst    <= dst_addr;
				ex_wb_sel <= sel_path_wb;
				for (int l = 0; l < N; l++) begin
					s  = sel_path[4] ? (l + int'(sel_path[3:0])) % N : l;
					ra = model_rf[s][src1_addr];              // Old value, no bypass
					rb = model_rf[s][src2_addr];
					rc = model_rf[s][src3_addr];
					if (!sel_path[4] && sel_path[1:0] != 2'd0) begin
						ra = (sel_path[1:0] == 2'd1) ? ra : (sel_path[1:0] == 2'd2) ? rb : rc;
						rb = ra;
						rc = ra;
					end else if (!sel_path[4] && sel_path[3]) begin
						rc = scalar;
					end
					ex_a[l] <= ra;
					ex_b[l] <= rb;
					ex_c[l] <= rc;
				end
			end
		end
	end

	////////////////////////////////////////////////////////////////
	// Result checks
	////////////////////////////////////////////////////////////////

	strobe_expected: assert property (@(posedge clk) disable iff (!rst_n) done |-> wb_v)
	else begin
		err_count++;
		$display("done was high at %0t with no instruction expected", $time);
	end

	for (genvar g = 0; g < N; g++) begin : g_check
		lane_value: assert property (@(posedge clk) disable iff (!rst_n)
			done |-> result[g] == exp_result[g])
		else begin
			err_count++;
			$display("Mismatch at %0t: lane %0d wrote %h, expected %h", $time, g,
				$sampled(result[g]), $sampled(exp_result[g]));
		end
	end

	function automatic lane_pkg::reg_addr_t pick_reg();
		return lane_pkg::reg_addr_t'($urandom_range(`RF_DEPTH - 1, 0));
	endfunction

	task automatic send_instr(input lane_pkg::alu_op_t f, input lane_pkg::reg_addr_t a1, a2, a3,
			input lane_pkg::reg_addr_t d, input lane_pkg::path_sel_t sp, sw,
			input lane_pkg::data_t k);
		@(posedge clk);
		issue       <= 1'b1;
		op          <= f;
		src1_addr   <= a1;
		src2_addr   <= a2;
		src3_addr   <= a3;
		dst_addr    <= d;
		sel_path    <= sp;
		sel_path_wb <= sw;
		scalar      <= k;
	endtask

	// Stop issuing and wait for the model pipeline to empty
	task automatic drain_pipe();
		@(posedge clk);
		issue <= 1'b0;
		do @(posedge clk); while (ex_v || wb_v);
	endtask

	task automatic close_test(input string name);
		int errs;
		errs = err_count + int'(dut_i.checker_i.error_count);
		if (errs == errs_seen) begin
			pass_count++;
			$display("Test %s: passed", name);
		end else begin
			fail_count++;
			$display("Test %s: failed with %0d errors", name, errs - errs_seen);
		end
		errs_seen = errs;
	endtask

	initial begin
		void'($urandom(85));
		rst_n = 1'b0;
		issue = 1'b0;
		op = lane_pkg::op_pass;
		src1_addr = '0;
		src2_addr = '0;
		src3_addr = '0;
		dst_addr = '0;
		sel_path = '0;
		sel_path_wb = '0;
		scalar = '0;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;

		// Scalar reaches a register as carried operand 3
		for (int k = 0; k < `RF_DEPTH; k++)
			send_instr(lane_pkg::op_pass, 0, 0, 0, 4'(k), 5'h08, 5'h03, $urandom);
		send_instr(lane_pkg::op_add, pick_reg(), pick_reg(), pick_reg(), pick_reg(), 0, 0, 0);
		send_instr(lane_pkg::op_sub, pick_reg(), pick_reg(), pick_reg(), pick_reg(), 0, 0, 0);
		send_instr(lane_pkg::op_mul_add, pick_reg(), pick_reg(), pick_reg(), pick_reg(), 0, 0, 0);
		send_instr(lane_pkg::op_max, pick_reg(), pick_reg(), pick_reg(), pick_reg(), 0, 0, 0);
		send_instr(lane_pkg::op_mul_add, pick_reg(), pick_reg(), 0, pick_reg(), 5'h08, 0, $urandom);
		drain_pipe();
		close_test("direct arithmetic");

		for (int code = 1; code <= 3; code++) begin
			send_instr(lane_pkg::op_add, pick_reg(), pick_reg(), pick_reg(), pick_reg(),
				5'(code), 0, 0);
			send_instr(lane_pkg::op_mul_add, pick_reg(), pick_reg(), pick_reg(), pick_reg(),
				5'(code), 0, 0);
		end
		drain_pipe();
		close_test("broadcast");

		for (int r = 0; r <= N + 1; r++)                 // Past the lane count to wrap
			send_instr(lane_pkg::op_mul_add, pick_reg(), pick_reg(), pick_reg(), pick_reg(),
				{1'b1, 4'(r)}, 0, 0);
		drain_pipe();
		close_test("lane rotation");

		send_instr(lane_pkg::op_add, 1, 2, 3, 10, 5'h00, 5'h11, 0);
		send_instr(lane_pkg::op_mul_add, 4, 5, 6, 11, 5'h00, 5'h13, 0);
		send_instr(lane_pkg::op_sub, 1, 2, 3, 12, 5'h08, 5'h03, $urandom);
		send_instr(lane_pkg::op_add, 7, 8, 9, 13, 5'h00, 5'h01, 0);
		send_instr(lane_pkg::op_add, 7, 8, 9, 14, 5'h00, 5'h02, 0);
		for (int d = 10; d <= 14; d++)
			send_instr(lane_pkg::op_pass, 4'(d), 0, 0, 15, 5'h00, 5'h00, 0);
		drain_pipe();
		close_test("write-back selection");

		send_instr(lane_pkg::op_pass, 0, 0, 0, 6, 5'h08, 5'h03, $urandom);
		send_instr(lane_pkg::op_add, 1, 2, 3, 7, 5'h00, 5'h00, 0);
		send_instr(lane_pkg::op_pass, 6, 6, 6, 8, 5'h00, 5'h00, 0);  // Reads while 6 is written
		for (int n = 0; n < 24; n++)
			send_instr(lane_pkg::alu_op_t'($urandom_range(4, 0)), pick_reg(), pick_reg(),
				pick_reg(), pick_reg(), lane_pkg::path_sel_t'($urandom_range(31, 0)),
				lane_pkg::path_sel_t'($urandom_range(31, 0)), $urandom);
		drain_pipe();
		close_test("back-to-back issue");

		@(posedge clk);
		rst_n <= 1'b0;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		for (int d = 0; d < 4; d++)
			send_instr(lane_pkg::op_pass, pick_reg(), 0, 0, 4'(d), 5'h00, 5'h00, 0);
		send_instr(lane_pkg::op_add, pick_reg(), pick_reg(), 0, 9, 5'h11, 5'h00, 0);
		drain_pipe();
		close_test("reset clear");

		$display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

//--- hw/lane_alu.sv
/*
 * Three-operand lane ALU, combinational. Results keep the low DATA_W
 * bits; unused opcodes give zero.
 */

`timescale 1ns/1ps

module lane_alu (
	input  lane_pkg::alu_op_t op,
	input  lane_pkg::data_t   a,
	input  lane_pkg::data_t   b,
	input  lane_pkg::data_t   c,
	output lane_pkg::data_t   y
);

	lane_pkg::data_t prod;
	logic            a_ge_b;

	assign prod   = a * b;                      // Low half only
	assign a_ge_b = $signed(a) >= $signed(b);   // Two's complement compare

	always_comb begin
		case (op)
			lane_pkg::op_add: begin
				y = a + b;
			end
			lane_pkg::op_sub: begin
				y = a - b;
			end
			lane_pkg::op_mul_add: begin
				y = prod + c;                       // Wraps on overflow
			end
			lane_pkg::op_max: begin
				y = a_ge_b ? a : b;
			end
			lane_pkg::op_pass: begin
				y = a;
			end
			default: begin
				y = '0;
			end
		endcase
	end

endmodule

//--- hw/lane_array.sv
/*
 * SIMD lane array top. All lanes run one instruction in lockstep with a
 * fixed two-cycle latency and no back-pressure. NUM_LANES is a power of two.
 */

`timescale 1ns/1ps
`include "lane_macros.svh"

module lane_array (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                issue,        // One instruction per pulse
	input  lane_pkg::alu_op_t   op,
	input  lane_pkg::reg_addr_t src1_addr,
	input  lane_pkg::reg_addr_t src2_addr,
	input  lane_pkg::reg_addr_t src3_addr,
	input  lane_pkg::reg_addr_t dst_addr,
	input  lane_pkg::path_sel_t sel_path,
	input  lane_pkg::path_sel_t sel_path_wb,
	input  lane_pkg::data_t     scalar,
	output logic                done,         // Two cycles after issue
	output lane_pkg::lane_t     result        // Written values, slot per lane
);

	////////////////////////////////////////////////////////////
	// Lane exchange buses
	////////////////////////////////////////////////////////////

	lane_pkg::lane_t         src1_bus;  // Register reads of each lane
	lane_pkg::lane_t         src2_bus;
	lane_pkg::lane_t         src3_bus;
	lane_pkg::lane_t         wb_bus;    // Write-back stage ALU results
	logic [`NUM_LANES-1:0]   lane_done;

	////////////////////////////////////////////////////////////
	// Lanes
	////////////////////////////////////////////////////////////

	for (genvar i = 0; i < `NUM_LANES; i++) begin : g_lane
		simd_lane #(.LANE_ID(i)) u_lane (
			.clk         (clk),
			.rst_n       (rst_n),
			.issue       (issue),
			.op          (op),
			.src1_addr   (src1_addr),
			.src2_addr   (src2_addr),
			.src3_addr   (src3_addr),
			.dst_addr    (dst_addr),
			.sel_path    (sel_path),
			.sel_path_wb (sel_path_wb),
			.scalar      (scalar),
			.src1_bus    (src1_bus),
			.src2_bus    (src2_bus),
			.src3_bus    (src3_bus),
			.wb_bus      (wb_bus),
			.src1_out    (src1_bus[i]),
			.src2_out    (src2_bus[i]),
			.src3_out    (src3_bus[i]),
			.wb_out      (wb_bus[i]),
			.wr_out      (result[i]),
			.done        (lane_done[i])
		);
	end

	// Lane 0 stands for all lanes in lockstep
	assign done = lane_done[0];

endmodule

//--- hw/lane_macros.svh
/*
 * Array size constants. NUM_LANES must be a power of two from 2 to 16,
 * because lane rotation wraps by dropping the upper index bits.
 */

`ifndef LANE_MACROS_SVH
`define LANE_MACROS_SVH

////////////////////////////////////////////////////////////
// Array geometry
////////////////////////////////////////////////////////////

// Lanes running in lockstep
`define NUM_LANES 4

// Operand and register width
`define DATA_W 32

////////////////////////////////////////////////////////////
// Register file
////////////////////////////////////////////////////////////

// Registers per lane, addressed by 4 bits
`define RF_DEPTH 16

`endif

//--- hw/lane_pkg.sv
/*
 * Shared types of the lane array. Widths follow lane_macros.svh.
 */

`include "lane_macros.svh"

package lane_pkg;

	typedef logic [`DATA_W-1:0] data_t;                  // One operand
	typedef logic [$clog2(`RF_DEPTH)-1:0] reg_addr_t;   // Register index

	// Path select
	//   [4]   lane mode, [3:0] rotation
	//   else  [1:0] source code, [3] scalar on operand 3 in direct mode
	typedef logic [4:0] path_sel_t;

	// One value per lane, slot i belongs to lane i
	typedef data_t [`NUM_LANES-1:0] lane_t;

	////////////////////////////////////////////////////////////
	// ALU opcodes
	////////////////////////////////////////////////////////////

	typedef enum logic [2:0] {
		op_add     = 3'd0,  // a + b
		op_sub     = 3'd1,  // a - b
		op_mul_add = 3'd2,  // a * b + c
		op_max     = 3'd3,  // Signed max of a and b
		op_pass    = 3'd4   // a
	} alu_op_t;

endpackage

//--- hw/lane_regfile.sv
/*
 * Per-lane register file. Reads are combinational with no write bypass,
 * so a read in the write cycle returns the old value.
 */

`timescale 1ns/1ps
`include "lane_macros.svh"

module lane_regfile (
	input  logic                clk,
	input  logic                rst_n,
	input  lane_pkg::reg_addr_t rd_addr1,
	input  lane_pkg::reg_addr_t rd_addr2,
	input  lane_pkg::reg_addr_t rd_addr3,
	output lane_pkg::data_t     rd_data1,
	output lane_pkg::data_t     rd_data2,
	output lane_pkg::data_t     rd_data3,
	input  logic                wr_en,
	input  lane_pkg::reg_addr_t wr_addr,
	input  lane_pkg::data_t     wr_data
);

	lane_pkg::data_t regs [`RF_DEPTH];

	////////////////////////////////////////////////////////////
	// Write port
	////////////////////////////////////////////////////////////

	// All registers read zero after reset
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int k = 0; k < `RF_DEPTH; k++) begin
				regs[k] <= '0;
			end
		end else if (wr_en) begin
			regs[wr_addr] <= wr_data;
		end
	end

	////////////////////////////////////////////////////////////
	// Read ports
	////////////////////////////////////////////////////////////

	assign rd_data1 = regs[rd_addr1];  // Operand 1
	assign rd_data2 = regs[rd_addr2];  // Operand 2
	assign rd_data3 = regs[rd_addr3];  // Operand 3

endmodule

//--- hw/path_sel.sv
/*
 * Operand and write-back source selection for one lane. Purely
 * combinational; rotation wraps modulo NUM_LANES.
 */

`timescale 1ns/1ps
`include "lane_macros.svh"

module path_sel #(
	parameter int LANE_ID = 0
)(
	input  logic                req,
	input  lane_pkg::path_sel_t sel_path,     // Operand select
	input  lane_pkg::path_sel_t sel_path_wb,  // Write-back select
	input  lane_pkg::data_t     scalar,
	input  lane_pkg::lane_t     lane_src1,    // Register reads of all lanes
	input  lane_pkg::lane_t     lane_src2,
	input  lane_pkg::lane_t     lane_src3,
	input  lane_pkg::lane_t     lane_wb,      // ALU results of all lanes
	input  lane_pkg::data_t     rf_src1,      // Own register reads
	input  lane_pkg::data_t     rf_src2,
	input  lane_pkg::data_t     rf_src3,
	input  lane_pkg::data_t     wb_result,    // Own write-back stage
	input  lane_pkg::data_t     wb_carry1,
	input  lane_pkg::data_t     wb_carry2,
	input  lane_pkg::data_t     wb_carry3,
	output lane_pkg::data_t     op_src1,      // To ALU
	output lane_pkg::data_t     op_src2,
	output lane_pkg::data_t     op_src3,
	output lane_pkg::data_t     wb_data,      // To register file
	output lane_pkg::data_t     bus_src1,     // To other lanes
	output lane_pkg::data_t     bus_src2,
	output lane_pkg::data_t     bus_src3
);

	localparam int LANE_W = $clog2(`NUM_LANES);

	logic [3:0]        src_rot;
	logic [3:0]        wb_rot;
	logic [LANE_W-1:0] src_lane;
	logic [LANE_W-1:0] wb_lane;
	lane_pkg::data_t   bcast;

	////////////////////////////////////////////////////////////
	// Source lane by rotation
	////////////////////////////////////////////////////////////

	assign src_rot  = sel_path[3:0] + 4'(LANE_ID);
	assign wb_rot   = sel_path_wb[3:0] + 4'(LANE_ID);
	assign src_lane = src_rot[LANE_W-1:0];  // Drop upper bits for wrap
	assign wb_lane  = wb_rot[LANE_W-1:0];

	////////////////////////////////////////////////////////////
	// Operand mux
	////////////////////////////////////////////////////////////

	always_comb begin
		case (sel_path[1:0])
			2'd2:    bcast = rf_src2;
			2'd3:    bcast = rf_src3;
			default: bcast = rf_src1;
		endcase
	end

	always_comb begin
		if (sel_path[4]) begin                   // Lane mode
			op_src1 = lane_src1[src_lane];
			op_src2 = lane_src2[src_lane];
			op_src3 = lane_src3[src_lane];
		end else if (sel_path[1:0] == 2'd0) begin // Direct mode
			op_src1 = rf_src1;
			op_src2 = rf_src2;
			op_src3 = sel_path[3] ? scalar : rf_src3;
		end else begin                            // Broadcast one read
			op_src1 = bcast;
			op_src2 = bcast;
			op_src3 = bcast;
		end
	end

	// Write-back value
	always_comb begin
		if (sel_path_wb[4])
			wb_data = lane_wb[wb_lane];
		else begin
			case (sel_path_wb[1:0])
				2'd1:    wb_data = wb_carry1;
				2'd2:    wb_data = wb_carry2;
				2'd3:    wb_data = wb_carry3;
				default: wb_data = wb_result;
			endcase
		end
	end

	assign bus_src1 = req ? rf_src1 : '0;  // Quiet bus when idle
	assign bus_src2 = req ? rf_src2 : '0;
	assign bus_src3 = req ? rf_src3 : '0;

endmodule

//--- hw/simd_lane.sv
/*
 * One lane with a two-cycle issue to write-back pipeline. Accepts an
 * instruction every cycle; wr_out is zero when nothing is written.
 */

`timescale 1ns/1ps

module simd_lane #(
	parameter int LANE_ID = 0
)(
	input  logic                clk,
	input  logic                rst_n,
	input  logic                issue,
	input  lane_pkg::alu_op_t   op,
	input  lane_pkg::reg_addr_t src1_addr,
	input  lane_pkg::reg_addr_t src2_addr,
	input  lane_pkg::reg_addr_t src3_addr,
	input  lane_pkg::reg_addr_t dst_addr,
	input  lane_pkg::path_sel_t sel_path,
	input  lane_pkg::path_sel_t sel_path_wb,
	input  lane_pkg::data_t     scalar,
	input  lane_pkg::lane_t     src1_bus,
	input  lane_pkg::lane_t     src2_bus,
	input  lane_pkg::lane_t     src3_bus,
	input  lane_pkg::lane_t     wb_bus,
	output lane_pkg::data_t     src1_out,
	output lane_pkg::data_t     src2_out,
	output lane_pkg::data_t     src3_out,
	output lane_pkg::data_t     wb_out,  // ALU result in write-back stage
	output lane_pkg::data_t     wr_out,  // Value written this cycle
	output logic                done
);

	lane_pkg::data_t     rf_rd1, rf_rd2, rf_rd3;
	lane_pkg::data_t     sel_src1, sel_src2, sel_src3;
	lane_pkg::data_t     alu_y;
	lane_pkg::data_t     wr_data;

	// Execute stage
	logic                ex_valid;
	lane_pkg::alu_op_t   ex_op;
	lane_pkg::reg_addr_t ex_dst;
	lane_pkg::path_sel_t ex_sel_wb;
	lane_pkg::data_t     ex_src1, ex_src2, ex_src3;

	// Write-back stage
	logic                wb_valid;
	lane_pkg::reg_addr_t wb_dst;
	lane_pkg::path_sel_t wb_sel_wb;
	lane_pkg::data_t     wb_result;
	lane_pkg::data_t     wb_carry1, wb_carry2, wb_carry3;

	lane_regfile u_rf (
		.clk(clk), .rst_n(rst_n),
		.rd_addr1(src1_addr), .rd_addr2(src2_addr), .rd_addr3(src3_addr),
		.rd_data1(rf_rd1), .rd_data2(rf_rd2), .rd_data3(rf_rd3),
		.wr_en(wb_valid), .wr_addr(wb_dst), .wr_data(wr_data)
	);

	path_sel #(.LANE_ID(LANE_ID)) u_sel (
		.req(issue), .sel_path(sel_path), .sel_path_wb(wb_sel_wb), .scalar(scalar),
		.lane_src1(src1_bus), .lane_src2(src2_bus), .lane_src3(src3_bus),
		.lane_wb(wb_bus),
		.rf_src1(rf_rd1), .rf_src2(rf_rd2), .rf_src3(rf_rd3),
		.wb_result(wb_result),
		.wb_carry1(wb_carry1), .wb_carry2(wb_carry2), .wb_carry3(wb_carry3),
		.op_src1(sel_src1), .op_src2(sel_src2), .op_src3(sel_src3),
		.wb_data(wr_data),
		.bus_src1(src1_out), .bus_src2(src2_out), .bus_src3(src3_out)
	);

	lane_alu u_alu (.op(ex_op), .a(ex_src1), .b(ex_src2), .c(ex_src3), .y(alu_y));

	////////////////////////////////////////////////////////////
	// Pipeline registers
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex_valid <= 1'b0;
			wb_valid <= 1'b0;
		end else begin
			ex_valid <= issue;
			wb_valid <= ex_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (issue) begin                // Operands chosen in issue cycle
			ex_op     <= op;
			ex_dst    <= dst_addr;
			ex_sel_wb <= sel_path_wb;
			ex_src1   <= sel_src1;
			ex_src2   <= sel_src2;
			ex_src3   <= sel_src3;
		end
		if (ex_valid) begin
			wb_dst    <= ex_dst;
			wb_sel_wb <= ex_sel_wb;
			wb_result <= alu_y;
			wb_carry1 <= ex_src1;         // Carried for write-back select
			wb_carry2 <= ex_src2;
			wb_carry3 <= ex_src3;
		end
	end

	assign wb_out = wb_result;
	assign wr_out = wb_valid ? wr_data : '0;
	assign done   = wb_valid;

endmodule

//--- run.sh
#!/bin/sh
# Compile and run the lane array testbench with Verilator, then check the log

rm -f sim.log && \
verilator --binary --timing --assert -Wno-fatal -f build.f \
	--top-module lane_array_tb -o lane_array_sim && \
./obj_dir/lane_array_sim +verilator+error+limit+1000 > sim.log 2>&1

cat sim.log
grep -q "Simulation completed successfully" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
